//--- src/tcb_lite_pkg.sv
////////////////////////////////////////////////////////////
// TCB-Lite shared widths, size/target types and helpers
// imported by the bridge RTL and the testbench
////////////////////////////////////////////////////////////

package tcb_lite_pkg;

    ////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////

    localparam int unsigned tcb_dat_w = 32;            // data width
    localparam int unsigned tcb_byt_w = tcb_dat_w/8;   // byte enable width

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    // logarithmic transfer size, 2'd3 (double word) is not supported here
    typedef enum logic [1:0] {
        tcb_siz_byte = 2'd0,  // 1 byte
        tcb_siz_half = 2'd1,  // 2 bytes
        tcb_siz_word = 2'd2   // 4 bytes
    } tcb_siz_t;

    // target manager port, picked by address MSB
    typedef enum logic {
        tcb_man_lo = 1'b0,
        tcb_man_hi = 1'b1
    } tcb_man_t;

    // byte offset inside the data word
    typedef logic [$clog2(tcb_byt_w)-1:0] tcb_off_t;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // byte mask for a size, anchored at lane 0
    function automatic logic [tcb_byt_w-1:0] tcb_siz_byt (
        input tcb_siz_t siz
    );
        case (siz)
            tcb_siz_byte: return 4'b0001;
            tcb_siz_half: return 4'b0011;
            tcb_siz_word: return 4'b1111;
            default:      return 4'b1111;  // oversize, flagged elsewhere
        endcase
    endfunction

endpackage: tcb_lite_pkg

//--- src/tcb_lite_decode.sv
////////////////////////////////////////////////////////////
// TCB-Lite request decoder, purely combinational
// logsize to byte enable, lane placement, target select
////////////////////////////////////////////////////////////

module tcb_lite_decode
    import tcb_lite_pkg::*;
#(
    parameter int unsigned ADR = 32  // address width, 8 to 32
)(
    // subordinate request fields
    input  logic [ADR-1:0]       req_adr,  // byte address
    input  tcb_siz_t             req_siz,  // logarithmic size
    input  logic [tcb_dat_w-1:0] req_wdt,  // write data, low bits
    // decoded request
    output logic [tcb_byt_w-1:0] dec_byt,  // byte enable
    output logic [tcb_dat_w-1:0] dec_wdt,  // write data in its lanes
    output tcb_man_t             dec_man,  // target manager
    output tcb_off_t             dec_off,  // byte offset
    output logic                 dec_err   // local error
);

    ////////////////////////////////////////////////////////////
    // local signals
    ////////////////////////////////////////////////////////////

    logic [tcb_byt_w-1:0] siz_byt;  // size mask at lane 0
    logic                 mis_aln;  // misaligned address
    logic                 ovr_siz;  // wider than the bus

    ////////////////////////////////////////////////////////////
    // alignment check
    ////////////////////////////////////////////////////////////

    assign dec_off = req_adr[$bits(tcb_off_t)-1:0];

    always_comb begin
        mis_aln = 1'b0;
        ovr_siz = 1'b0;
        case (req_siz)
            tcb_siz_byte: mis_aln = 1'b0;             // any address
            tcb_siz_half: mis_aln = dec_off[0];       // even addresses
            tcb_siz_word: mis_aln = |dec_off;         // word aligned
            default: begin
                ovr_siz = 1'b1;                       // 8 bytes on a 4 byte bus
            end
        endcase
    end

    assign dec_err = mis_aln | ovr_siz;

    ////////////////////////////////////////////////////////////
    // byte enable and write lanes
    ////////////////////////////////////////////////////////////

    assign siz_byt = tcb_siz_byt(req_siz);

    // little endian lane placement
    assign dec_byt = siz_byt << dec_off;
    assign dec_wdt = req_wdt << {dec_off, 3'b000};  // offset in bits

    ////////////////////////////////////////////////////////////
    // target select
    ////////////////////////////////////////////////////////////

    // upper half of the address map goes to the high manager
    assign dec_man = tcb_man_t'(req_adr[ADR-1]);

endmodule: tcb_lite_decode

//--- src/tcb_lite_execute.sv
////////////////////////////////////////////////////////////
// TCB-Lite request register with back-pressure and demux
// one held request, vld raised on the selected manager only
////////////////////////////////////////////////////////////

module tcb_lite_execute
    import tcb_lite_pkg::*;
#(
    parameter int unsigned ADR = 32  // address width
)(
    // system signals
    input  logic                 clk,
    input  logic                 rst,
    // subordinate handshake and fields
    input  logic                 sub_vld,
    output logic                 sub_rdy,
    input  logic                 sub_req_lck,
    input  logic                 sub_req_ndn,
    input  logic                 sub_req_wen,
    // decoded request
    input  logic [ADR-1:0]       dec_adr,
    input  logic [tcb_byt_w-1:0] dec_byt,
    input  logic [tcb_dat_w-1:0] dec_wdt,
    input  tcb_man_t             dec_man,
    input  tcb_off_t             dec_off,
    input  logic                 dec_err,
    input  tcb_siz_t             dec_siz,
    // low manager
    output logic                 man_lo_vld,
    input  logic                 man_lo_rdy,
    output logic                 man_lo_req_lck,
    output logic                 man_lo_req_ndn,
    output logic                 man_lo_req_wen,
    output logic [ADR-1:0]       man_lo_req_adr,
    output logic [tcb_byt_w-1:0] man_lo_req_byt,
    output logic [tcb_dat_w-1:0] man_lo_req_wdt,
    // high manager
    output logic                 man_hi_vld,
    input  logic                 man_hi_rdy,
    output logic                 man_hi_req_lck,
    output logic                 man_hi_req_ndn,
    output logic                 man_hi_req_wen,
    output logic [ADR-1:0]       man_hi_req_adr,
    output logic [tcb_byt_w-1:0] man_hi_req_byt,
    output logic [tcb_dat_w-1:0] man_hi_req_wdt,
    // completion pulse to result
    output logic                 cmp_vld,
    output tcb_man_t             cmp_man,
    output logic                 cmp_err,
    output tcb_off_t             cmp_off,
    output tcb_siz_t             cmp_siz
);

    ////////////////////////////////////////////////////////////
    // request register
    ////////////////////////////////////////////////////////////

    logic                 req_vld;  // register occupied
    logic                 req_err;  // local error, never shown
    tcb_man_t             req_man;
    tcb_off_t             req_off;
    tcb_siz_t             req_siz;
    logic                 req_lck;
    logic                 req_ndn;
    logic                 req_wen;
    logic [ADR-1:0]       req_adr;
    logic [tcb_byt_w-1:0] req_byt;
    logic [tcb_dat_w-1:0] req_wdt;

    logic man_rdy;   // ready of the selected manager
    logic man_trn;   // manager transfer
    logic err_ret;   // error retirement
    logic req_done;  // register frees up this cycle

    assign man_rdy  = (req_man == tcb_man_hi) ? man_hi_rdy : man_lo_rdy;
    assign man_trn  = req_vld & ~req_err & man_rdy;
    assign err_ret  = req_vld &  req_err;  // one cycle, no manager involved
    assign req_done = man_trn | err_ret;

    // accept when empty or draining
    assign sub_rdy = ~req_vld | req_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_vld <= 1'b0;
        end else if (sub_rdy) begin
            req_vld <= sub_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (sub_vld & sub_rdy) begin  // subordinate transfer
            req_err <= dec_err;
            req_man <= dec_man;
            req_off <= dec_off;
            req_siz <= dec_siz;
            req_lck <= sub_req_lck;
            req_ndn <= sub_req_ndn;
            req_wen <= sub_req_wen;
            req_adr <= dec_adr;
            req_byt <= dec_byt;
            req_wdt <= dec_wdt;
        end
    end

    ////////////////////////////////////////////////////////////
    // demultiplexer
    ////////////////////////////////////////////////////////////

    assign man_lo_vld = req_vld & ~req_err & (req_man == tcb_man_lo);
    assign man_hi_vld = req_vld & ~req_err & (req_man == tcb_man_hi);

    // shared fields, only vld tells them apart
    assign man_lo_req_lck = req_lck;
    assign man_lo_req_ndn = req_ndn;
    assign man_lo_req_wen = req_wen;
    assign man_lo_req_adr = req_adr;
    assign man_lo_req_byt = req_byt;
    assign man_lo_req_wdt = req_wdt;
    assign man_hi_req_lck = req_lck;
    assign man_hi_req_ndn = req_ndn;
    assign man_hi_req_wen = req_wen;
    assign man_hi_req_adr = req_adr;
    assign man_hi_req_byt = req_byt;
    assign man_hi_req_wdt = req_wdt;

    // completion record
    assign cmp_vld = req_done;
    assign cmp_man = req_man;
    assign cmp_err = req_err;
    assign cmp_off = req_off;
    assign cmp_siz = req_siz;

endmodule: tcb_lite_execute

//--- src/tcb_lite_result.sv
////////////////////////////////////////////////////////////
// TCB-Lite response path, one cycle after completion
// selects the manager and moves read data to the low bits
////////////////////////////////////////////////////////////

module tcb_lite_result
    import tcb_lite_pkg::*;
(
    // system signals
    input  logic                 clk,
    input  logic                 rst,
    // completion pulse from execute
    input  logic                 cmp_vld,
    input  tcb_man_t             cmp_man,
    input  logic                 cmp_err,
    input  tcb_off_t             cmp_off,
    input  tcb_siz_t             cmp_siz,
    // manager responses
    input  logic [tcb_dat_w-1:0] man_lo_rsp_rdt,
    input  logic                 man_lo_rsp_err,
    input  logic [tcb_dat_w-1:0] man_hi_rsp_rdt,
    input  logic                 man_hi_rsp_err,
    // subordinate response
    output logic [tcb_dat_w-1:0] sub_rsp_rdt,
    output logic                 sub_rsp_err
);

    logic                 rsp_vld;  // response due this cycle
    tcb_man_t             rsp_man;
    logic                 rsp_lcl;  // local error record
    tcb_off_t             rsp_off;
    tcb_siz_t             rsp_siz;

    logic [tcb_dat_w-1:0] man_rdt;  // selected read data
    logic                 man_err;
    logic [tcb_byt_w-1:0] siz_byt;
    logic [tcb_dat_w-1:0] rdt_msk;  // bit mask for the size

    always_ff @(posedge clk) begin
        if (rst) rsp_vld <= 1'b0;
        else     rsp_vld <= cmp_vld;
    end

    always_ff @(posedge clk) begin
        if (cmp_vld) begin
            rsp_man <= cmp_man;
            rsp_lcl <= cmp_err;
            rsp_off <= cmp_off;
            rsp_siz <= cmp_siz;
        end
    end

    assign man_rdt = (rsp_man == tcb_man_hi) ? man_hi_rsp_rdt : man_lo_rsp_rdt;
    assign man_err = (rsp_man == tcb_man_hi) ? man_hi_rsp_err : man_lo_rsp_err;

    // expand byte mask to bits
    assign siz_byt = tcb_siz_byt(rsp_siz);
    always_comb begin
        for (int i = 0; i < tcb_byt_w; i++) begin
            rdt_msk[8*i +: 8] = {8{siz_byt[i]}};
        end
    end

    // local error wins, no data
    assign sub_rsp_rdt = rsp_lcl ? '0 : (man_rdt >> {rsp_off, 3'b000}) & rdt_msk;
    assign sub_rsp_err = rsp_vld & (rsp_lcl | man_err);

endmodule: tcb_lite_result

//--- src/tcb_lite_top.sv
////////////////////////////////////////////////////////////
// TCB-Lite bridge, logsize subordinate to two byte enable
// managers split by address MSB
////////////////////////////////////////////////////////////

module tcb_lite_top
    import tcb_lite_pkg::*;
#(
    parameter int unsigned ADR = 32  // address width, 8 to 32
)(
    // system signals
    input  logic                 clk,
    input  logic                 rst,
    // subordinate port
    input  logic                 sub_vld,
    output logic                 sub_rdy,
    input  logic                 sub_req_lck,
    input  logic                 sub_req_ndn,
    input  logic                 sub_req_wen,
    input  logic [ADR-1:0]       sub_req_adr,
    input  tcb_siz_t             sub_req_siz,
    input  logic [tcb_dat_w-1:0] sub_req_wdt,
    output logic [tcb_dat_w-1:0] sub_rsp_rdt,
    output logic                 sub_rsp_err,
    // low manager port
    output logic                 man_lo_vld,
    input  logic                 man_lo_rdy,
    output logic                 man_lo_req_lck,
    output logic                 man_lo_req_ndn,
    output logic                 man_lo_req_wen,
    output logic [ADR-1:0]       man_lo_req_adr,
    output logic [tcb_byt_w-1:0] man_lo_req_byt,
    output logic [tcb_dat_w-1:0] man_lo_req_wdt,
    input  logic [tcb_dat_w-1:0] man_lo_rsp_rdt,
    input  logic                 man_lo_rsp_err,
    // high manager port
    output logic                 man_hi_vld,
    input  logic                 man_hi_rdy,
    output logic                 man_hi_req_lck,
    output logic                 man_hi_req_ndn,
    output logic                 man_hi_req_wen,
    output logic [ADR-1:0]       man_hi_req_adr,
    output logic [tcb_byt_w-1:0] man_hi_req_byt,
    output logic [tcb_dat_w-1:0] man_hi_req_wdt,
    input  logic [tcb_dat_w-1:0] man_hi_rsp_rdt,
    input  logic                 man_hi_rsp_err
);

    ////////////////////////////////////////////////////////////
    // local signals
    ////////////////////////////////////////////////////////////

    logic [tcb_byt_w-1:0] dec_byt;
    logic [tcb_dat_w-1:0] dec_wdt;
    tcb_man_t             dec_man;
    tcb_off_t             dec_off;
    logic                 dec_err;

    logic                 cmp_vld;  // completion pulse
    tcb_man_t             cmp_man;
    logic                 cmp_err;
    tcb_off_t             cmp_off;
    tcb_siz_t             cmp_siz;

    ////////////////////////////////////////////////////////////
    // pipeline
    ////////////////////////////////////////////////////////////

    tcb_lite_decode #(.ADR (ADR)) decode (
        .req_adr (sub_req_adr), .req_siz (sub_req_siz), .req_wdt (sub_req_wdt),
        .dec_byt (dec_byt), .dec_wdt (dec_wdt), .dec_man (dec_man),
        .dec_off (dec_off), .dec_err (dec_err)
    );

    tcb_lite_execute #(.ADR (ADR)) execute (
        .clk (clk), .rst (rst),
        .sub_vld (sub_vld), .sub_rdy (sub_rdy),
        .sub_req_lck (sub_req_lck), .sub_req_ndn (sub_req_ndn), .sub_req_wen (sub_req_wen),
        .dec_adr (sub_req_adr), .dec_byt (dec_byt), .dec_wdt (dec_wdt), .dec_man (dec_man),
        .dec_off (dec_off), .dec_err (dec_err), .dec_siz (sub_req_siz),
        .man_lo_vld (man_lo_vld), .man_lo_rdy (man_lo_rdy),
        .man_lo_req_lck (man_lo_req_lck), .man_lo_req_ndn (man_lo_req_ndn),
        .man_lo_req_wen (man_lo_req_wen), .man_lo_req_adr (man_lo_req_adr),
        .man_lo_req_byt (man_lo_req_byt), .man_lo_req_wdt (man_lo_req_wdt),
        .man_hi_vld (man_hi_vld), .man_hi_rdy (man_hi_rdy),
        .man_hi_req_lck (man_hi_req_lck), .man_hi_req_ndn (man_hi_req_ndn),
        .man_hi_req_wen (man_hi_req_wen), .man_hi_req_adr (man_hi_req_adr),
        .man_hi_req_byt (man_hi_req_byt), .man_hi_req_wdt (man_hi_req_wdt),
        .cmp_vld (cmp_vld), .cmp_man (cmp_man), .cmp_err (cmp_err),
        .cmp_off (cmp_off), .cmp_siz (cmp_siz)
    );

    tcb_lite_result result (
        .clk (clk), .rst (rst),
        .cmp_vld (cmp_vld), .cmp_man (cmp_man), .cmp_err (cmp_err),
        .cmp_off (cmp_off), .cmp_siz (cmp_siz),
        .man_lo_rsp_rdt (man_lo_rsp_rdt), .man_lo_rsp_err (man_lo_rsp_err),
        .man_hi_rsp_rdt (man_hi_rsp_rdt), .man_hi_rsp_err (man_hi_rsp_err),
        .sub_rsp_rdt (sub_rsp_rdt), .sub_rsp_err (sub_rsp_err)
    );

endmodule: tcb_lite_top

//--- dv/tcb_lite_mem_model.sv
////////////////////////////////////////////////////////////
// byte enable memory for one bridge manager port, 256 bytes
// answers one cycle after each transfer, random ready
////////////////////////////////////////////////////////////

module tcb_lite_mem_model
    import tcb_lite_pkg::*;
#(
    parameter int unsigned ADR     = 16,      // address width
    parameter bit          RND_RDY = 1'b1,    // random ready, else always high
    parameter int          SEED    = 92863    // $random seed
)(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 vld,
    output logic                 rdy = 1'b0,
    input  logic                 wen,
    input  logic [ADR-1:0]       adr,
    input  logic [tcb_byt_w-1:0] byt,
    input  logic [tcb_dat_w-1:0] wdt,
    output logic [tcb_dat_w-1:0] rdt = '0,
    output logic                 err = 1'b0
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] mem [0:255];
    integer     seed;
    logic       out_rng;  // outside the 256 byte array
    logic [7:0] base;     // word base inside the array

    initial seed = SEED;

    assign out_rng = |adr[ADR-2:8];  // bit ADR-1 is the window select
    assign base    = {adr[7:2], 2'b00};

    always @(posedge clk) begin
        if (rst) begin
            rdy <= 1'b0;
            rdt <= '0;
            err <= 1'b0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= 8'h00;
            end
        end else begin
            rdy <= RND_RDY ? (($random(seed) & 3) != 0) : 1'b1;  // about 3 in 4
            err <= 1'b0;
            if (vld && rdy) begin
                err <= out_rng;
                rdt <= '0;  // writes and errors answer zero
                if (!out_rng && wen) begin
                    for (int i = 0; i < tcb_byt_w; i++) begin
                        if (byt[i]) mem[base + 8'(i)] <= wdt[8*i +: 8];
                    end
                end else if (!out_rng) begin
                    rdt <= {mem[base + 8'd3], mem[base + 8'd2], mem[base + 8'd1], mem[base]};
                end
            end
        end
    end

endmodule: tcb_lite_mem_model

//--- dv/tcb_lite_tb.sv
////////////////////////////////////////////////////////////
// bridge testbench driven by cases from a hex data file
// two memory models sit on the manager ports
////////////////////////////////////////////////////////////

module tcb_lite_tb
    import tcb_lite_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ADR       = 16;
    localparam int MAX_CASES = 128;
    localparam int FIELDS    = 6;  // wen siz adr wdt err rdt

    logic clk, rst;
    logic sub_vld, sub_rdy, sub_req_lck, sub_req_ndn, sub_req_wen;
    logic [ADR-1:0] sub_req_adr;
    tcb_siz_t       sub_req_siz;
    logic [31:0]    sub_req_wdt, sub_rsp_rdt;
    logic           sub_rsp_err;
    // manager side
    logic man_lo_vld, man_lo_rdy, man_lo_req_lck, man_lo_req_ndn, man_lo_req_wen, man_lo_rsp_err;
    logic man_hi_vld, man_hi_rdy, man_hi_req_lck, man_hi_req_ndn, man_hi_req_wen, man_hi_rsp_err;
    logic [ADR-1:0] man_lo_req_adr, man_hi_req_adr;
    logic [3:0]     man_lo_req_byt, man_hi_req_byt;
    logic [31:0]    man_lo_req_wdt, man_hi_req_wdt, man_lo_rsp_rdt, man_hi_rsp_rdt;

    logic [31:0] case_mem [0:FIELDS*MAX_CASES-1];
    int          n_cases, nxt, errors, checks, limit;
    int          cycles = 0;
    bit          rsp_due, lcl_in_reg, done;
    int          exp_idx_q [$];  // outstanding cases in transfer order
    logic [31:0] exp_rdt_q [$];
    logic        exp_err_q [$];
    // request taken into the bridge register at the last edge
    bit          fresh_req, fresh_hi;
    int          held_id;
    logic        held_lck, held_ndn;
    logic [1:0]  exp_vld;        // {hi, lo}

    tcb_lite_top #(.ADR (ADR)) tcb_lite_top_inst (.*);

    tcb_lite_mem_model #(.ADR (ADR)) mem_lo (
        .clk (clk), .rst (rst), .vld (man_lo_vld), .rdy (man_lo_rdy), .wen (man_lo_req_wen),
        .adr (man_lo_req_adr), .byt (man_lo_req_byt), .wdt (man_lo_req_wdt),
        .rdt (man_lo_rsp_rdt), .err (man_lo_rsp_err)
    );

    tcb_lite_mem_model #(.ADR (ADR)) mem_hi (
        .clk (clk), .rst (rst), .vld (man_hi_vld), .rdy (man_hi_rdy), .wen (man_hi_req_wen),
        .adr (man_hi_req_adr), .byt (man_hi_req_byt), .wdt (man_hi_req_wdt),
        .rdt (man_hi_rsp_rdt), .err (man_hi_rsp_err)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    always @(posedge clk) cycles <= cycles + 1;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // bridge local error rule from size and low address bits
    function automatic bit misaligned(input logic [1:0] siz, input logic [ADR-1:0] adr);
        case (siz)
            2'd0:    return 1'b0;
            2'd1:    return adr[0];
            2'd2:    return adr[1:0] != 2'b00;
            default: return 1'b1;  // double word on a 32 bit bus
        endcase
    endfunction

    task automatic drive_case(input int i);
        sub_vld     = 1'b1;
        sub_req_lck = i[0];  // lock and endianness toggle per case
        sub_req_ndn = i[1];
        sub_req_wen = case_mem[FIELDS*i][0];
        sub_req_siz = tcb_siz_t'(case_mem[FIELDS*i + 1][1:0]);
        sub_req_adr = case_mem[FIELDS*i + 2][ADR-1:0];
        sub_req_wdt = case_mem[FIELDS*i + 3];
    endtask

    task automatic check_response();
        int          id;
        logic [31:0] e_rdt;
        logic        e_err;
        if (exp_idx_q.size() == 0) begin
            errors++;
            $display("response came with no request outstanding");
        end else begin
            id    = exp_idx_q.pop_front();
            e_rdt = exp_rdt_q.pop_front();
            e_err = exp_err_q.pop_front();
            checks++;
            if (sub_rsp_err !== e_err) begin
                errors++;
                $display("Error case %0d err: expected %0b, actual %0b", id, e_err, sub_rsp_err);
            end
            if (sub_rsp_rdt !== e_rdt) begin
                errors++;
                $display("Error case %0d rdt: expected %h, actual %h", id, e_rdt, sub_rsp_rdt);
            end
        end
    endtask

    // lck and ndn pass to the manager unchanged
    task automatic verify_lck_ndn(input logic lck, input logic ndn);
        if (lck !== held_lck) begin
            errors++;
            $display("Error case %0d lck: expected %0b, actual %0b", held_id, held_lck, lck);
        end
        if (ndn !== held_ndn) begin
            errors++;
            $display("Error case %0d ndn: expected %0b, actual %0b", held_id, held_ndn, ndn);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main flow
    ////////////////////////////////////////////////////////////

    initial begin
        rst = 1'b1;
        sub_vld = 1'b0;
        sub_req_lck = 1'b0;
        sub_req_ndn = 1'b0;
        sub_req_wen = 1'b0;
        sub_req_adr = '0;
        sub_req_siz = tcb_siz_byte;
        sub_req_wdt = '0;
        {nxt, errors, checks, rsp_due, lcl_in_reg, done} = '0;
        fresh_req = 1'b0;
        fresh_hi  = 1'b0;
        held_id   = 0;
        held_lck  = 1'b0;
        held_ndn  = 1'b0;
        exp_vld   = 2'b00;
        for (int i = 0; i < FIELDS*MAX_CASES; i++) case_mem[i] = '1;  // end marker
        $readmemh("dv/tcb_lite_cases.txt", case_mem);
        n_cases = 0;
        while (n_cases < MAX_CASES && case_mem[FIELDS*n_cases] !== '1) n_cases++;
        if (n_cases == 0) begin
            errors++;
            $display("no cases were read from the case file");
        end
        limit = 40 * n_cases;
        repeat (16) @(posedge clk);
        @(negedge clk);
        if (man_lo_vld !== 1'b0 || man_hi_vld !== 1'b0 || sub_rdy !== 1'b1) begin
            errors++;
            $display("after reset a manager vld is not low or sub_rdy is not high");
        end
        rst = 1'b0;
        done = (n_cases == 0);
        while (!done) begin
            @(negedge clk);  // everything from the last edge has settled
            if (rsp_due) begin
                check_response();
            end else if (sub_rsp_err !== 1'b0) begin
                errors++;
                $display("err raised outside a response cycle");
            end
            if (lcl_in_reg && (man_lo_vld || man_hi_vld)) begin
                errors++;
                $display("a manager saw vld for a request with a local error");
            end
            // address bit 15 picks the manager, vld one cycle after transfer
            if (fresh_req && !lcl_in_reg) begin
                exp_vld = fresh_hi ? 2'b10 : 2'b01;
                if ({man_hi_vld, man_lo_vld} !== exp_vld) begin
                    errors++;
                    $display("Error case %0d vld hi lo: expected %b, actual %b",
                             held_id, exp_vld, {man_hi_vld, man_lo_vld});
                end
            end
            if (man_lo_vld) begin
                verify_lck_ndn(man_lo_req_lck, man_lo_req_ndn);
            end
            if (man_hi_vld) begin
                verify_lck_ndn(man_hi_req_lck, man_hi_req_ndn);
            end
            // completion at the next edge means a response one cycle later
            rsp_due = lcl_in_reg || (man_lo_vld && man_lo_rdy) || (man_hi_vld && man_hi_rdy);
            lcl_in_reg = 1'b0;
            fresh_req  = 1'b0;
            if (nxt < n_cases) begin
                drive_case(nxt);  // same fields again while stalled
                if (sub_rdy) begin
                    exp_idx_q.push_back(nxt);
                    exp_err_q.push_back(case_mem[FIELDS*nxt + 4][0]);
                    exp_rdt_q.push_back(case_mem[FIELDS*nxt + 5]);
                    lcl_in_reg = misaligned(case_mem[FIELDS*nxt + 1][1:0],
                                            case_mem[FIELDS*nxt + 2][ADR-1:0]);
                    held_id   = nxt;
                    held_lck  = sub_req_lck;
                    held_ndn  = sub_req_ndn;
                    fresh_hi  = case_mem[FIELDS*nxt + 2][ADR-1];
                    fresh_req = 1'b1;
                    nxt++;
                end
            end else begin
                sub_vld = 1'b0;
            end
            done = (nxt == n_cases) && (exp_idx_q.size() == 0) && !rsp_due;
        end
        $display("cases: %0d, checks: %0d, errors: %0d", n_cases, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog at 40 cycles per case
    initial begin
        wait (limit != 0);
        wait (cycles >= limit);
        $display("timeout after %0d cycles, checks: %0d, errors: %0d", limit, checks, errors);
        $display("Result: FAILED");
        $finish;
    end

endmodule: tcb_lite_tb

//--- dv/tcb_lite_cases.txt
// columns: wen siz adr wdt exp_err exp_rdt, all hex, one transfer per line
// siz 0 byte, 1 half, 2 word, 3 double; adr bit 15 picks the high manager
1 2 0010 11223344 0 00000000
0 2 0010 00000000 0 11223344
0 1 0012 00000000 0 00001122
0 1 0010 00000000 0 00003344
0 0 0011 00000000 0 00000033
0 0 0013 00000000 0 00000011
1 1 8022 aaaabeef 0 00000000
0 2 8020 00000000 0 beef0000
0 1 8022 00000000 0 0000beef
1 0 8031 ffffffa5 0 00000000
0 0 8031 00000000 0 000000a5
0 2 8030 00000000 0 0000a500
1 0 0040 0000005a 0 00000000
1 0 0042 0000003c 0 00000000
0 2 0040 00000000 0 003c005a
1 2 0050 cafef00d 0 00000000
1 0 0051 00000077 0 00000000
0 2 0050 00000000 0 cafe770d
0 1 0011 00000000 1 00000000
1 2 8022 deadbeef 1 00000000
0 2 0012 00000000 1 00000000
0 3 0010 00000000 1 00000000
0 2 8020 00000000 0 beef0000
0 2 8010 00000000 0 00000000
0 2 0020 00000000 0 00000000
1 2 8010 0badcafe 0 00000000
0 2 0010 00000000 0 11223344
0 2 8010 00000000 0 0badcafe
0 2 0100 00000000 1 00000000
1 0 c000 00000012 1 00000000
0 0 81ff 00000000 1 00000000
1 2 00fc 89abcdef 0 00000000
0 0 00fe 00000000 0 000000ab
0 1 00fc 00000000 0 0000cdef
0 0 80ff 00000000 0 00000000

//--- flist.f
src/tcb_lite_pkg.sv
src/tcb_lite_decode.sv
src/tcb_lite_execute.sv
src/tcb_lite_result.sv
src/tcb_lite_top.sv
dv/tcb_lite_mem_model.sv
dv/tcb_lite_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the bridge testbench with Verilator and run it from the project root.
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f flist.f --top-module tcb_lite_tb \
    --Mdir obj_dir -o tcb_lite_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tcb_lite_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0
